// File: verilog/backend_defs.svh
// architectural sizes and micro-op field positions for the dual-issue backend.
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// number of architectural integer registers.
`define NUM_REGS 32

// data word and register number widths.
`define WIDTH_WORD 32
`define WIDTH_REG_ADDR 5

// stable counter width, read in two halves.
`define WIDTH_CNT 64

// micro-op width.
`define WIDTH_UOP 7

// micro-op fields.
//   [2:0] alu operation
//   [4:3] source 1 select
//   [6:5] source 2 select
`define UOP_ALU_OP 2:0
`define UOP_SRC1 4:3
`define UOP_SRC2 6:5

`endif

// File: verilog/backend_pkg.sv
// shared types and encodings for the operand and execute stages.
`default_nettype none

`include "backend_defs.svh"

package backend_pkg;

    typedef logic [`WIDTH_WORD-1:0] word_t;
    typedef logic [`WIDTH_REG_ADDR-1:0] reg_addr_t;
    typedef logic [`WIDTH_UOP-1:0] uop_t;
    typedef logic [`WIDTH_CNT-1:0] cnt_t;

    // code 2'd3 is reserved and reads as zero.
    typedef enum logic [1:0] {
        SRC1_RF   = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RF   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,
        SRC2_CNTH = 2'd3
    } src2_sel_t;

    // shifts take the low 5 bits of operand 2.
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLL  = 3'd5,
        ALU_SRL  = 3'd6,
        ALU_SLTU = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/stable_counter.sv
// free-running 64-bit time counter.
`default_nettype none

module stable_counter (
    input  logic                clk,
    input  logic                reset,
    output backend_pkg::cnt_t   count
);

    // wraps to zero after the top value.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/operand_read.sv
// register file, write collision, forwarding, operand selection and read-stage register.
`default_nettype none

`include "backend_defs.svh"

module operand_read (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    write_en_0,
    input  logic                    write_en_1,
    input  backend_pkg::reg_addr_t  write_addr_0,
    input  backend_pkg::reg_addr_t  write_addr_1,
    input  backend_pkg::word_t      write_data_0,
    input  backend_pkg::word_t      write_data_1,
    input  backend_pkg::cnt_t       count,
    input  logic                    issue_en_0,
    input  backend_pkg::uop_t       issue_uop_0,
    input  backend_pkg::reg_addr_t  issue_rd_0,
    input  backend_pkg::reg_addr_t  issue_rj_0,
    input  backend_pkg::reg_addr_t  issue_rk_0,
    input  backend_pkg::word_t      issue_pc_0,
    input  backend_pkg::word_t      issue_imm_0,
    input  logic                    issue_en_1,
    input  backend_pkg::uop_t       issue_uop_1,
    input  backend_pkg::reg_addr_t  issue_rd_1,
    input  backend_pkg::reg_addr_t  issue_rj_1,
    input  backend_pkg::reg_addr_t  issue_rk_1,
    input  backend_pkg::word_t      issue_pc_1,
    input  backend_pkg::word_t      issue_imm_1,
    output logic                    rd_en_0,
    output backend_pkg::uop_t       rd_uop_0,
    output backend_pkg::reg_addr_t  rd_rd_0,
    output backend_pkg::word_t      rd_src1_0,
    output backend_pkg::word_t      rd_src2_0,
    output logic                    rd_en_1,
    output backend_pkg::uop_t       rd_uop_1,
    output backend_pkg::reg_addr_t  rd_rd_1,
    output backend_pkg::word_t      rd_src1_1,
    output backend_pkg::word_t      rd_src2_1
);

    import backend_pkg::*;

    word_t regs [`NUM_REGS];

    word_t rf_j_0;
    word_t rf_k_0;
    word_t rf_j_1;
    word_t rf_k_1;

    // zero register first, then port 1, then port 0, then storage.
    function automatic word_t rf_resolve(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (write_en_1 && write_addr_1 == addr) begin
            return write_data_1;
        end else if (write_en_0 && write_addr_0 == addr) begin
            return write_data_0;
        end
        return regs[addr];
    endfunction

    function automatic word_t select_src1(logic [1:0] sel, word_t rf, word_t pc);
        case (src1_sel_t'(sel))
            SRC1_RF:   return rf;
            SRC1_PC:   return pc;
            SRC1_ZERO: return '0;
            default:   return '0;
        endcase
    endfunction

    function automatic word_t select_src2(logic [1:0] sel, word_t rf, word_t imm, cnt_t cnt);
        case (src2_sel_t'(sel))
            SRC2_RF:   return rf;
            SRC2_IMM:  return imm;
            SRC2_CNTL: return cnt[31:0];
            SRC2_CNTH: return cnt[63:32];
            default:   return '0;
        endcase
    endfunction

    // port 1 wins when both ports hit the same register.
    always_ff @(posedge clk) begin
        if (write_en_0 && !(write_en_1 && write_addr_1 == write_addr_0)) begin
            regs[write_addr_0] <= (write_addr_0 == '0) ? '0 : write_data_0;
        end
        if (write_en_1) begin
            regs[write_addr_1] <= (write_addr_1 == '0) ? '0 : write_data_1;
        end
    end

    always_comb begin
        rf_j_0 = rf_resolve(issue_rj_0);
        rf_k_0 = rf_resolve(issue_rk_0);
        rf_j_1 = rf_resolve(issue_rj_1);
        rf_k_1 = rf_resolve(issue_rk_1);
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_en_0 <= 1'b0;
            rd_en_1 <= 1'b0;
        end else if (!stall) begin
            rd_en_0 <= issue_en_0;
            rd_en_1 <= issue_en_1;
        end
    end

    // operands are captured with the count seen at the issue edge.
    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_uop_0  <= issue_uop_0;
            rd_rd_0   <= issue_rd_0;
            rd_src1_0 <= select_src1(issue_uop_0[`UOP_SRC1], rf_j_0, issue_pc_0);
            rd_src2_0 <= select_src2(issue_uop_0[`UOP_SRC2], rf_k_0, issue_imm_0, count);
            rd_uop_1  <= issue_uop_1;
            rd_rd_1   <= issue_rd_1;
            rd_src1_1 <= select_src1(issue_uop_1[`UOP_SRC1], rf_j_1, issue_pc_1);
            rd_src2_1 <= select_src2(issue_uop_1[`UOP_SRC2], rf_k_1, issue_imm_1, count);
        end
    end

    flush_empties_read: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !(rd_en_0 || rd_en_1)
    ) else $error("read stage valid in the cycle after flush");

endmodule

`default_nettype wire

// File: verilog/alu_execute.sv
// per-lane alu and execute-stage register driving retire and write-back.
`default_nettype none

`include "backend_defs.svh"

module alu_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    rd_en_0,
    input  backend_pkg::uop_t       rd_uop_0,
    input  backend_pkg::reg_addr_t  rd_rd_0,
    input  backend_pkg::word_t      rd_src1_0,
    input  backend_pkg::word_t      rd_src2_0,
    input  logic                    rd_en_1,
    input  backend_pkg::uop_t       rd_uop_1,
    input  backend_pkg::reg_addr_t  rd_rd_1,
    input  backend_pkg::word_t      rd_src1_1,
    input  backend_pkg::word_t      rd_src2_1,
    output logic                    ret_en_0,
    output backend_pkg::reg_addr_t  ret_rd_0,
    output backend_pkg::word_t      ret_data_0,
    output logic                    ret_en_1,
    output backend_pkg::reg_addr_t  ret_rd_1,
    output backend_pkg::word_t      ret_data_1
);

    import backend_pkg::*;

    word_t result_0;
    word_t result_1;

    function automatic word_t alu_calc(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SLTU: return word_t'(a < b);
            default:  return '0;
        endcase
    endfunction

    always_comb begin
        result_0 = alu_calc(alu_op_t'(rd_uop_0[`UOP_ALU_OP]), rd_src1_0, rd_src2_0);
        result_1 = alu_calc(alu_op_t'(rd_uop_1[`UOP_ALU_OP]), rd_src1_1, rd_src2_1);
    end

    // a stall inserts a bubble while the read stage holds its micro-ops.
    always_ff @(posedge clk) begin
        if (reset || flush || stall) begin
            ret_en_0 <= 1'b0;
            ret_en_1 <= 1'b0;
        end else begin
            ret_en_0 <= rd_en_0;
            ret_en_1 <= rd_en_1;
        end
    end

    always_ff @(posedge clk) begin
        ret_rd_0   <= rd_rd_0;
        ret_data_0 <= result_0;
        ret_rd_1   <= rd_rd_1;
        ret_data_1 <= result_1;
    end

    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> !(ret_en_0 || ret_en_1)
    ) else $error("retire seen in the cycle after stall");

endmodule

`default_nettype wire

// File: verilog/dual_issue_backend.sv
// top level joining the counter, the read stage and the execute stage.
`default_nettype none

module dual_issue_backend (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    issue_en_0,
    input  backend_pkg::uop_t       issue_uop_0,
    input  backend_pkg::reg_addr_t  issue_rd_0,
    input  backend_pkg::reg_addr_t  issue_rj_0,
    input  backend_pkg::reg_addr_t  issue_rk_0,
    input  backend_pkg::word_t      issue_pc_0,
    input  backend_pkg::word_t      issue_imm_0,
    input  logic                    issue_en_1,
    input  backend_pkg::uop_t       issue_uop_1,
    input  backend_pkg::reg_addr_t  issue_rd_1,
    input  backend_pkg::reg_addr_t  issue_rj_1,
    input  backend_pkg::reg_addr_t  issue_rk_1,
    input  backend_pkg::word_t      issue_pc_1,
    input  backend_pkg::word_t      issue_imm_1,
    output logic                    ret_en_0,
    output backend_pkg::reg_addr_t  ret_rd_0,
    output backend_pkg::word_t      ret_data_0,
    output logic                    ret_en_1,
    output backend_pkg::reg_addr_t  ret_rd_1,
    output backend_pkg::word_t      ret_data_1
);

    import backend_pkg::*;

    cnt_t count;

    logic      rd_en_0;
    uop_t      rd_uop_0;
    reg_addr_t rd_rd_0;
    word_t     rd_src1_0;
    word_t     rd_src2_0;
    logic      rd_en_1;
    uop_t      rd_uop_1;
    reg_addr_t rd_rd_1;
    word_t     rd_src1_1;
    word_t     rd_src2_1;

    stable_counter i_stable_counter (
        .clk   (clk),
        .reset (reset),
        .count (count)
    );

    // retire outputs double as the register file write ports.
    operand_read i_operand_read (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .write_en_0   (ret_en_0),
        .write_en_1   (ret_en_1),
        .write_addr_0 (ret_rd_0),
        .write_addr_1 (ret_rd_1),
        .write_data_0 (ret_data_0),
        .write_data_1 (ret_data_1),
        .count        (count),
        .issue_en_0   (issue_en_0),
        .issue_uop_0  (issue_uop_0),
        .issue_rd_0   (issue_rd_0),
        .issue_rj_0   (issue_rj_0),
        .issue_rk_0   (issue_rk_0),
        .issue_pc_0   (issue_pc_0),
        .issue_imm_0  (issue_imm_0),
        .issue_en_1   (issue_en_1),
        .issue_uop_1  (issue_uop_1),
        .issue_rd_1   (issue_rd_1),
        .issue_rj_1   (issue_rj_1),
        .issue_rk_1   (issue_rk_1),
        .issue_pc_1   (issue_pc_1),
        .issue_imm_1  (issue_imm_1),
        .rd_en_0      (rd_en_0),
        .rd_uop_0     (rd_uop_0),
        .rd_rd_0      (rd_rd_0),
        .rd_src1_0    (rd_src1_0),
        .rd_src2_0    (rd_src2_0),
        .rd_en_1      (rd_en_1),
        .rd_uop_1     (rd_uop_1),
        .rd_rd_1      (rd_rd_1),
        .rd_src1_1    (rd_src1_1),
        .rd_src2_1    (rd_src2_1)
    );

    alu_execute i_alu_execute (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .rd_en_0    (rd_en_0),
        .rd_uop_0   (rd_uop_0),
        .rd_rd_0    (rd_rd_0),
        .rd_src1_0  (rd_src1_0),
        .rd_src2_0  (rd_src2_0),
        .rd_en_1    (rd_en_1),
        .rd_uop_1   (rd_uop_1),
        .rd_rd_1    (rd_rd_1),
        .rd_src1_1  (rd_src1_1),
        .rd_src2_1  (rd_src2_1),
        .ret_en_0   (ret_en_0),
        .ret_rd_0   (ret_rd_0),
        .ret_data_0 (ret_data_0),
        .ret_en_1   (ret_en_1),
        .ret_rd_1   (ret_rd_1),
        .ret_data_1 (ret_data_1)
    );

endmodule

`default_nettype wire

// File: bench/tb_dual_issue_backend.sv
// directed testbench for the dual-issue operand and execute slice, with a reference register model.
`default_nettype none

`include "backend_defs.svh"

module tb_dual_issue_backend;

    timeunit 1ns;
    timeprecision 1ps;

    import backend_pkg::*;

    localparam int TIMEOUT = 12;
    localparam int RESET_CYCLES = 3;

    logic      clk;
    logic      reset;
    logic      stall;
    logic      flush;
    logic      issue_en_0;
    uop_t      issue_uop_0;
    reg_addr_t issue_rd_0;
    reg_addr_t issue_rj_0;
    reg_addr_t issue_rk_0;
    word_t     issue_pc_0;
    word_t     issue_imm_0;
    logic      issue_en_1;
    uop_t      issue_uop_1;
    reg_addr_t issue_rd_1;
    reg_addr_t issue_rj_1;
    reg_addr_t issue_rk_1;
    word_t     issue_pc_1;
    word_t     issue_imm_1;
    logic      ret_en_0;
    reg_addr_t ret_rd_0;
    word_t     ret_data_0;
    logic      ret_en_1;
    reg_addr_t ret_rd_1;
    word_t     ret_data_1;

    // reference register file and the expected retire of each lane.
    word_t     model_regs [`NUM_REGS];
    logic      exp_en [2];
    reg_addr_t exp_rd [2];
    word_t     exp_data [2];
    int        errors;
    int        checks;

    // rising edges since time zero, reset included.
    int        edge_count = 0;

    dual_issue_backend i_dual_issue_backend (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    function automatic uop_t make_uop(alu_op_t op, src1_sel_t s1, src2_sel_t s2);
        uop_t u;
        u = '0;
        u[`UOP_ALU_OP] = op;
        u[`UOP_SRC1] = s1;
        u[`UOP_SRC2] = s2;
        return u;
    endfunction

    function automatic word_t model_read(reg_addr_t r);
        return (r == '0) ? '0 : model_regs[r];
    endfunction

    // shifts use only the low five bits of b.
    function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
        word_t res;
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a + ~b + 32'd1;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            default:  res = (a < b) ? 32'd1 : 32'd0;
        endcase
        return res;
    endfunction

    // counter value seen by a micro-op issued at the next rising edge.
    function automatic word_t count_at_next_edge();
        return word_t'(edge_count - RESET_CYCLES);
    endfunction

    task automatic compare_word(string test, string what, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", test, what, exp, act);
        end
    endtask

    task automatic idle_inputs();
        issue_en_0 = 1'b0;
        issue_uop_0 = '0;
        issue_rd_0 = '0;
        issue_rj_0 = '0;
        issue_rk_0 = '0;
        issue_pc_0 = '0;
        issue_imm_0 = '0;
        issue_en_1 = 1'b0;
        issue_uop_1 = '0;
        issue_rd_1 = '0;
        issue_rj_1 = '0;
        issue_rk_1 = '0;
        issue_pc_1 = '0;
        issue_imm_1 = '0;
    endtask

    // sets up one lane for the next rising edge and predicts its result.
    task automatic drive_lane(int lane, uop_t uop, reg_addr_t rd, reg_addr_t rj,
                              reg_addr_t rk, word_t pc, word_t imm);
        word_t a;
        word_t b;
        case (src1_sel_t'(uop[`UOP_SRC1]))
            SRC1_RF: a = model_read(rj);
            SRC1_PC: a = pc;
            default: a = '0;
        endcase
        case (src2_sel_t'(uop[`UOP_SRC2]))
            SRC2_RF:  b = model_read(rk);
            SRC2_IMM: b = imm;
            default:  b = '0;
        endcase
        exp_en[lane] = 1'b1;
        exp_rd[lane] = rd;
        exp_data[lane] = ref_alu(alu_op_t'(uop[`UOP_ALU_OP]), a, b);
        if (lane == 0) begin
            issue_en_0 = 1'b1;
            issue_uop_0 = uop;
            issue_rd_0 = rd;
            issue_rj_0 = rj;
            issue_rk_0 = rk;
            issue_pc_0 = pc;
            issue_imm_0 = imm;
        end else begin
            issue_en_1 = 1'b1;
            issue_uop_1 = uop;
            issue_rd_1 = rd;
            issue_rj_1 = rj;
            issue_rk_1 = rk;
            issue_pc_1 = pc;
            issue_imm_1 = imm;
        end
    endtask

    // stall stays high for the first stall_cycles edges after the issue edge.
    task automatic wait_retire(string test, int stall_cycles, output int cycles);
        @(posedge clk);
        @(negedge clk);
        issue_en_0 = 1'b0;
        issue_en_1 = 1'b0;
        cycles = 1;
        stall = (stall_cycles >= 1);
        while (!(ret_en_0 || ret_en_1) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            stall = (cycles <= stall_cycles);
        end
        stall = 1'b0;
        if (!(ret_en_0 || ret_en_1)) begin
            errors++;
            $display("timeout in %s: no retire within %0d cycles", test, TIMEOUT);
        end
    endtask

    task automatic retire_and_check(string test, int stall_cycles);
        int cycles;
        wait_retire(test, stall_cycles, cycles);
        if (ret_en_0 || ret_en_1) begin
            compare_word(test, "latency", word_t'(2 + stall_cycles), word_t'(cycles));
            compare_word(test, "ret_en_0", word_t'(exp_en[0]), word_t'(ret_en_0));
            compare_word(test, "ret_en_1", word_t'(exp_en[1]), word_t'(ret_en_1));
            if (exp_en[0]) begin
                compare_word(test, "ret_rd_0", word_t'(exp_rd[0]), word_t'(ret_rd_0));
                compare_word(test, "ret_data_0", exp_data[0], ret_data_0);
            end
            if (exp_en[1]) begin
                compare_word(test, "ret_rd_1", word_t'(exp_rd[1]), word_t'(ret_rd_1));
                compare_word(test, "ret_data_1", exp_data[1], ret_data_1);
            end
            // lane 1 goes last so it wins a shared destination.
            for (int n = 0; n < 2; n++) begin
                if (exp_en[n] && exp_rd[n] != '0) begin
                    model_regs[exp_rd[n]] = exp_data[n];
                end
            end
        end
        exp_en[0] = 1'b0;
        exp_en[1] = 1'b0;
    endtask

    task automatic test_reset_zero();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (ret_en_0 || ret_en_1) begin
                errors++;
                $display("test_reset_zero saw a retire after reset with nothing issued");
            end
        end
        drive_lane(0, make_uop(ALU_ADD, SRC1_RF, SRC2_RF), 5'd3, 5'd0, 5'd0, '0, '0);
        retire_and_check("test_reset_zero", 0);
        drive_lane(1, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), 5'd0, 5'd0, 5'd0, '0,
                   32'h1234_5678);
        retire_and_check("test_reset_zero", 0);
        drive_lane(0, make_uop(ALU_ADD, SRC1_RF, SRC2_RF), 5'd4, 5'd0, 5'd0, '0, '0);
        retire_and_check("test_reset_zero", 0);
    endtask

    task automatic test_alu_sources();
        src2_sel_t s2_lane0;
        src2_sel_t s2_lane1;
        for (int i = 0; i < 4; i++) begin
            drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), reg_addr_t'(2 * i + 1),
                       '0, '0, '0, $urandom);
            drive_lane(1, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), reg_addr_t'(2 * i + 2),
                       '0, '0, '0, $urandom);
            retire_and_check("test_alu_sources", 0);
        end
        // second pass swaps the operand 2 sources between the lanes.
        for (int pass = 0; pass < 2; pass++) begin
            s2_lane0 = (pass == 0) ? SRC2_RF : SRC2_IMM;
            s2_lane1 = (pass == 0) ? SRC2_IMM : SRC2_RF;
            for (int op = 0; op < 8; op++) begin
                drive_lane(0, make_uop(alu_op_t'(op), SRC1_RF, s2_lane0), reg_addr_t'(16 + op),
                           reg_addr_t'(1 + $urandom % 8), reg_addr_t'(1 + $urandom % 8),
                           '0, $urandom);
                drive_lane(1, make_uop(alu_op_t'(op), SRC1_PC, s2_lane1), reg_addr_t'(24 + op),
                           '0, reg_addr_t'(1 + $urandom % 8), $urandom, $urandom);
                retire_and_check("test_alu_sources", 0);
            end
        end
    endtask

    task automatic test_forwarding();
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), 5'd10, '0, '0, '0, $urandom);
        retire_and_check("test_forwarding", 0);
        drive_lane(1, make_uop(ALU_OR, SRC1_RF, SRC2_IMM), 5'd12, 5'd10, '0, '0, '0);
        retire_and_check("test_forwarding", 0);
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), 5'd11, '0, '0, '0, $urandom);
        drive_lane(1, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), 5'd11, '0, '0, '0, $urandom);
        retire_and_check("test_forwarding", 0);
        drive_lane(0, make_uop(ALU_ADD, SRC1_RF, SRC2_RF), 5'd13, 5'd11, 5'd0, '0, '0);
        retire_and_check("test_forwarding", 0);
        // read again once the value sits in the register file.
        repeat (2) @(negedge clk);
        drive_lane(1, make_uop(ALU_ADD, SRC1_RF, SRC2_RF), 5'd13, 5'd11, 5'd0, '0, '0);
        retire_and_check("test_forwarding", 0);
    endtask

    task automatic test_stall_flush();
        int k;
        k = 1 + int'($urandom % 4);
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), 5'd14, '0, '0, '0, $urandom);
        drive_lane(1, make_uop(ALU_SUB, SRC1_PC, SRC2_IMM), 5'd15, '0, '0, $urandom, $urandom);
        retire_and_check("test_stall_flush", k);
        @(negedge clk);
        if (ret_en_0 || ret_en_1) begin
            errors++;
            $display("test_stall_flush saw the stalled micro-op retire a second time");
        end
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_IMM), 5'd14, '0, '0, '0,
                   ~model_regs[14]);
        @(posedge clk);
        @(negedge clk);
        exp_en[0] = 1'b0;
        flush = 1'b1;
        // the issue still offered at the flush edge must be dropped too.
        @(negedge clk);
        issue_en_0 = 1'b0;
        flush = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (ret_en_0 || ret_en_1) begin
                errors++;
                $display("test_stall_flush saw a flushed micro-op retire");
            end
            @(negedge clk);
        end
        drive_lane(0, make_uop(ALU_ADD, SRC1_RF, SRC2_RF), 5'd16, 5'd14, 5'd0, '0, '0);
        retire_and_check("test_stall_flush", 0);
    endtask

    task automatic test_counter();
        int cycles;
        word_t cnt_at_issue;
        cnt_at_issue = count_at_next_edge();
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTL), 5'd0, '0, '0, '0, '0);
        drive_lane(1, make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTL), 5'd0, '0, '0, '0, '0);
        wait_retire("test_counter", 0, cycles);
        compare_word("test_counter", "same edge ret_en", 32'd3,
                     word_t'({ret_en_1, ret_en_0}));
        compare_word("test_counter", "same edge cntl 0", cnt_at_issue, ret_data_0);
        compare_word("test_counter", "same edge cntl 1", cnt_at_issue, ret_data_1);
        @(negedge clk);
        cnt_at_issue = count_at_next_edge();
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTL), 5'd0, '0, '0, '0, '0);
        @(posedge clk);
        @(negedge clk);
        drive_lane(0, make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTL), 5'd0, '0, '0, '0, '0);
        drive_lane(1, make_uop(ALU_ADD, SRC1_ZERO, SRC2_CNTH), 5'd0, '0, '0, '0, '0);
        wait_retire("test_counter", 0, cycles);
        compare_word("test_counter", "first edge ret_en", 32'd1,
                     word_t'({ret_en_1, ret_en_0}));
        compare_word("test_counter", "first edge cntl", cnt_at_issue, ret_data_0);
        @(negedge clk);
        compare_word("test_counter", "ret_en after next edge", 32'd3,
                     word_t'({ret_en_1, ret_en_0}));
        compare_word("test_counter", "next edge cntl", cnt_at_issue + 32'd1, ret_data_0);
        compare_word("test_counter", "cnth", 32'd0, ret_data_1);
        exp_en[0] = 1'b0;
        exp_en[1] = 1'b0;
    endtask

    initial begin
        void'($urandom(32'ha0e7));
        errors = 0;
        checks = 0;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        idle_inputs();
        exp_en[0] = 1'b0;
        exp_en[1] = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_zero();
        test_alu_sources();
        test_forwarding();
        test_stall_flush();
        test_counter();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dual_issue_backend.f
+incdir+verilog
verilog/backend_pkg.sv
verilog/stable_counter.sv
verilog/operand_read.sv
verilog/alu_execute.sv
verilog/dual_issue_backend.sv
bench/tb_dual_issue_backend.sv

// File: Makefile
TOP := tb_dual_issue_backend

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f dual_issue_backend.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing -Wall -f dual_issue_backend.f --top-module $(TOP)

clean:
	rm -rf obj_dir
